// File: Bender.yml
package:
  name: convUnit

sources:
  # package first, then the expander, the register slave and the top level
  - common/convPkg.sv
  - exconv/convFp8Exp12.sv
  - exconv/convRgb30aExpand.sv
  - hdl/convRegSlave.sv
  - hdl/convUnit.sv

  # testbench, only for simulation
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tbConvUnit.sv

// File: common/convPkg.sv
package convPkg;

	// -------------------------------------------------------------------------
	// bus geometry of the register port
	// -------------------------------------------------------------------------

	// four word registers need only a 4-bit byte address
	localparam int ADDR_WIDTH = 4;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	// the expanded pixel is four 16-bit lanes
	localparam int PIXEL_WIDTH = 64;

	// register offsets, word aligned
	localparam logic [ADDR_WIDTH-1:0] REG_SRC    = 4'h0;
	localparam logic [ADDR_WIDTH-1:0] REG_FMT    = 4'h4;
	localparam logic [ADDR_WIDTH-1:0] REG_RES_LO = 4'h8;
	localparam logic [ADDR_WIDTH-1:0] REG_RES_HI = 4'hC;

	// -------------------------------------------------------------------------
	// format tag and half-float constants
	// -------------------------------------------------------------------------

	localparam int FMT_WIDTH         = 2;
	// set means the fields carry no sign
	localparam int FMT_UNSIGNED_BIT  = 0;
	// set means each field is a minifloat, clear means linear 10-bit colour
	localparam int FMT_MINIFLOAT_BIT = 1;

	// 1.0 as a binary16 with its low nibble dropped
	localparam logic [11:0] HALF_ONE_12 = 12'h3C0;

	// E4 bias 7 to E5 bias 15
	localparam logic [4:0] HALF_BIAS_ADJ = 5'd8;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: convUnit.f
+incdir+sim
common/convPkg.sv
exconv/convFp8Exp12.sv
exconv/convRgb30aExpand.sv
hdl/convRegSlave.sv
hdl/convUnit.sv
sim/tbConvUnit.sv

// File: exconv/convFp8Exp12.sv
module convFp8Exp12 import convPkg::*;
(
	input  logic [7:0]  fieldIn,
	input  logic        isSigned,
	output logic [11:0] halfOut
);

	// -------------------------------------------------------------------------
	// field split
	// -------------------------------------------------------------------------

	// the signed form is S.E4.M3, the unsigned form E4.M4
	logic       signBit;
	logic [3:0] expField;
	logic [5:0] mantAligned;

	// exponent rebiased into the five bits of a half
	logic [4:0] expHalf;
	logic       expZero;

	always_comb
	begin
		if (isSigned)
		begin
			signBit     = fieldIn[7];
			expField    = fieldIn[6:3];
			// three mantissa bits sit at the top of the six kept ones
			mantAligned = {fieldIn[2:0], 3'b000};
		end
		else
		begin
			// no sign, so the exponent moves up and the mantissa gains a bit
			signBit     = 1'b0;
			expField    = fieldIn[7:4];
			mantAligned = {fieldIn[3:0], 2'b00};
		end
	end

	// -------------------------------------------------------------------------
	// rebias and flush
	// -------------------------------------------------------------------------

	// a biased exponent of at most 15 plus 8 still fits in five bits
	assign expHalf = {1'b0, expField} + HALF_BIAS_ADJ;

	// denormals are not carried through, a zero exponent means zero
	assign expZero = (expField == 4'h0);

	always_comb
	begin
		if (expZero)
		begin
			halfOut = 12'h000;
		end
		else
		begin
			halfOut = {signBit, expHalf, mantAligned};
		end
	end

endmodule

// File: exconv/convRgb30aExpand.sv
module convRgb30aExpand import convPkg::*;
(
	input  logic [DATA_WIDTH-1:0]  srcWord,
	input  logic [FMT_WIDTH-1:0]   fmtTag,
	output logic [PIXEL_WIDTH-1:0] pixelOut
);

	// tag bit 0 set means unsigned, so the sign flag is its inverse
	logic isSigned;

	// minifloat fields, R and B get a zero bit below their seven
	logic [7:0] fpA;
	logic [7:0] fpR;
	logic [7:0] fpG;
	logic [7:0] fpB;

	// lanes out of the minifloat converters
	logic [11:0] expLaneA;
	logic [11:0] expLaneR;
	logic [11:0] expLaneG;
	logic [11:0] expLaneB;

	// lanes built from the 10-bit linear fields
	logic [11:0] linLaneR;
	logic [11:0] linLaneG;
	logic [11:0] linLaneB;

	// lanes after the mode select
	logic [11:0] laneA;
	logic [11:0] laneR;
	logic [11:0] laneG;
	logic [11:0] laneB;

	// a linear colour field gets a sign copy or a zero above it, and one zero below
	function automatic logic [11:0] linLane(input logic [9:0] field, input logic signedMode);
		logic topBit;
		topBit = signedMode ? field[9] : 1'b0;
		return {topBit, field, 1'b0};
	endfunction

	assign isSigned = !fmtTag[FMT_UNSIGNED_BIT];

	// -------------------------------------------------------------------------
	// minifloat path
	// -------------------------------------------------------------------------

	// the A and G fields are a full byte, R and B only seven bits wide
	assign fpA = srcWord[29:22];
	assign fpR = {srcWord[21:15], 1'b0};
	assign fpG = srcWord[14:7];
	assign fpB = {srcWord[6:0], 1'b0};

	convFp8Exp12 expA (.fieldIn(fpA), .isSigned(isSigned), .halfOut(expLaneA));
	convFp8Exp12 expR (.fieldIn(fpR), .isSigned(isSigned), .halfOut(expLaneR));
	convFp8Exp12 expG (.fieldIn(fpG), .isSigned(isSigned), .halfOut(expLaneG));
	convFp8Exp12 expB (.fieldIn(fpB), .isSigned(isSigned), .halfOut(expLaneB));

	// -------------------------------------------------------------------------
	// linear path
	// -------------------------------------------------------------------------

	// top two bits of the source word are not used by the linear layout
	assign linLaneR = linLane(srcWord[29:20], isSigned);
	assign linLaneG = linLane(srcWord[19:10], isSigned);
	assign linLaneB = linLane(srcWord[9:0], isSigned);

	// -------------------------------------------------------------------------
	// mode select and packing
	// -------------------------------------------------------------------------

	always_comb
	begin
		if (fmtTag[FMT_MINIFLOAT_BIT])
		begin
			laneA = expLaneA;
			laneR = expLaneR;
			laneG = expLaneG;
			laneB = expLaneB;
		end
		else
		begin
			// linear mode has no alpha field, so alpha is opaque
			laneA = HALF_ONE_12;
			laneR = linLaneR;
			laneG = linLaneG;
			laneB = linLaneB;
		end
	end

	// each lane fills the top twelve bits of a half, the low nibble stays zero
	assign pixelOut = {laneA, 4'h0, laneR, 4'h0, laneG, 4'h0, laneB, 4'h0};

endmodule

// File: hdl/convRegSlave.sv
module convRegSlave import convPkg::*;
(
	input  logic                   clock,
	input  logic                   arstN,

	// write address
	input  logic                   awValid,
	output logic                   awReady,
	input  logic [ADDR_WIDTH-1:0]  awAddr,

	// write data
	input  logic                   wValid,
	output logic                   wReady,
	input  logic [DATA_WIDTH-1:0]  wData,
	input  logic [STRB_WIDTH-1:0]  wStrb,

	// write response
	output logic                   bValid,
	input  logic                   bReady,
	output logic [1:0]             bResp,

	// read address
	input  logic                   arValid,
	output logic                   arReady,
	input  logic [ADDR_WIDTH-1:0]  arAddr,

	// read data
	output logic                   rValid,
	input  logic                   rReady,
	output logic [DATA_WIDTH-1:0]  rData,
	output logic [1:0]             rResp,

	// towards the expander
	output logic [DATA_WIDTH-1:0]  srcWord,
	output logic [FMT_WIDTH-1:0]   fmtTag,
	input  logic [PIXEL_WIDTH-1:0] pixelOut
);

	// address or data taken while its partner has not yet arrived
	logic awFull;
	logic wFull;

	// held copies of whichever half of the write came first
	logic [ADDR_WIDTH-1:0] awAddrQ;
	logic [DATA_WIDTH-1:0] wDataQ;
	logic [STRB_WIDTH-1:0] wStrbQ;

	logic awFire;
	logic wFire;
	logic arFire;

	// the write as seen in the cycle it completes
	logic                  wrGo;
	logic [ADDR_WIDTH-1:0] wrAddr;
	logic [DATA_WIDTH-1:0] wrData;
	logic [STRB_WIDTH-1:0] wrStrb;
	logic [ADDR_WIDTH-1:0] wrOffset;
	logic                  wrIsResult;

	logic [ADDR_WIDTH-1:0] rdOffset;
	logic [DATA_WIDTH-1:0] rdMux;

	// -------------------------------------------------------------------------
	// write channel handshakes
	// -------------------------------------------------------------------------

	// each channel stops once its own half is held or a response waits
	assign awReady = !bValid && !awFull;
	assign wReady  = !bValid && !wFull;

	assign awFire = awValid && awReady;
	assign wFire  = wValid && wReady;

	// a held half wins over the bus, since the bus may already carry the next one
	assign wrAddr = awFull ? awAddrQ : awAddr;
	assign wrData = wFull ? wDataQ : wData;
	assign wrStrb = wFull ? wStrbQ : wStrb;

	// the write is complete when both halves are either held or arriving now
	assign wrGo = (awFull || awFire) && (wFull || wFire);

	// byte lanes within a word are ignored by the decode
	assign wrOffset   = {wrAddr[ADDR_WIDTH-1:2], 2'b00};
	assign wrIsResult = (wrOffset == REG_RES_LO) || (wrOffset == REG_RES_HI);

	// -------------------------------------------------------------------------
	// read channel
	// -------------------------------------------------------------------------

	// no new address while a read response is still on the bus
	assign arReady = !rValid;
	assign arFire  = arValid && arReady;

	assign rdOffset = {arAddr[ADDR_WIDTH-1:2], 2'b00};

	always_comb
	begin
		case (rdOffset)
			REG_SRC:    rdMux = srcWord;
			// the tag sits in the low bits, everything above reads zero
			REG_FMT:    rdMux = {{(DATA_WIDTH-FMT_WIDTH){1'b0}}, fmtTag};
			REG_RES_LO: rdMux = pixelOut[DATA_WIDTH-1:0];
			REG_RES_HI: rdMux = pixelOut[PIXEL_WIDTH-1:DATA_WIDTH];
			default:    rdMux = '0;
		endcase
	end

	// reads of any offset succeed
	assign rResp = RESP_OKAY;

	// -------------------------------------------------------------------------
	// control state and registers
	// -------------------------------------------------------------------------

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			awFull  <= 1'b0;
			wFull   <= 1'b0;
			bValid  <= 1'b0;
			rValid  <= 1'b0;
			srcWord <= '0;
			fmtTag  <= '0;
		end
		else
		begin
			if (wrGo)
			begin
				// both halves are consumed here and the response goes out next
				awFull <= 1'b0;
				wFull  <= 1'b0;
				bValid <= 1'b1;
				case (wrOffset)
					REG_SRC:
					begin
						for (int i = 0; i < STRB_WIDTH; i++)
						begin
							if (wrStrb[i])
							begin
								srcWord[8*i +: 8] <= wrData[8*i +: 8];
							end
						end
					end
					REG_FMT:
					begin
						// only byte 0 holds anything for the tag
						if (wrStrb[0])
						begin
							fmtTag <= wrData[FMT_WIDTH-1:0];
						end
					end
					default:
					begin
						// result offsets are read-only and stay untouched
					end
				endcase
			end
			else
			begin
				if (awFire)
				begin
					awFull <= 1'b1;
				end
				if (wFire)
				begin
					wFull <= 1'b1;
				end
				if (bValid && bReady)
				begin
					bValid <= 1'b0;
				end
			end

			if (arFire)
			begin
				rValid <= 1'b1;
			end
			else if (rValid && rReady)
			begin
				rValid <= 1'b0;
			end
		end
	end

	// payload captures, only meaningful while their flag or valid is set
	always_ff @(posedge clock)
	begin
		if (awFire)
		begin
			awAddrQ <= awAddr;
		end
		if (wFire)
		begin
			wDataQ <= wData;
			wStrbQ <= wStrb;
		end
		if (wrGo)
		begin
			bResp <= wrIsResult ? RESP_SLVERR : RESP_OKAY;
		end
		// rData freezes under back-pressure because arReady is low then
		if (arFire)
		begin
			rData <= rdMux;
		end
	end

endmodule

// File: hdl/convUnit.sv
module convUnit import convPkg::*;
(
	input  logic                  clock,
	input  logic                  arstN,

	// AXI4-Lite slave port
	input  logic                  awValid,
	output logic                  awReady,
	input  logic [ADDR_WIDTH-1:0] awAddr,

	input  logic                  wValid,
	output logic                  wReady,
	input  logic [DATA_WIDTH-1:0] wData,
	input  logic [STRB_WIDTH-1:0] wStrb,

	output logic                  bValid,
	input  logic                  bReady,
	output logic [1:0]            bResp,

	input  logic                  arValid,
	output logic                  arReady,
	input  logic [ADDR_WIDTH-1:0] arAddr,

	output logic                  rValid,
	input  logic                  rReady,
	output logic [DATA_WIDTH-1:0] rData,
	output logic [1:0]            rResp
);

	// source register and tag feed the expander, its result comes back for reads
	logic [DATA_WIDTH-1:0]  srcWord;
	logic [FMT_WIDTH-1:0]   fmtTag;
	logic [PIXEL_WIDTH-1:0] pixelOut;

	convRegSlave regs (
		.clock    (clock),
		.arstN    (arstN),
		.awValid  (awValid),
		.awReady  (awReady),
		.awAddr   (awAddr),
		.wValid   (wValid),
		.wReady   (wReady),
		.wData    (wData),
		.wStrb    (wStrb),
		.bValid   (bValid),
		.bReady   (bReady),
		.bResp    (bResp),
		.arValid  (arValid),
		.arReady  (arReady),
		.arAddr   (arAddr),
		.rValid   (rValid),
		.rReady   (rReady),
		.rData    (rData),
		.rResp    (rResp),
		.srcWord  (srcWord),
		.fmtTag   (fmtTag),
		.pixelOut (pixelOut)
	);

	// purely combinational, a result read sees the current source and tag
	convRgb30aExpand expand (
		.srcWord  (srcWord),
		.fmtTag   (fmtTag),
		.pixelOut (pixelOut)
	);

endmodule

// File: sim/convRefModel.svh
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

	// -------------------------------------------------------------------------
	// expected lanes, worked out with integer arithmetic on the field values
	// -------------------------------------------------------------------------

	// one 8-bit minifloat, S.E4.M3 when signed and E4.M4 when unsigned
	function automatic logic [11:0] refFp8Exp12(input logic [7:0] field, input bit isSigned);
		int signVal;
		int expVal;
		int mantVal;
		int result;
		if (isSigned)
		begin
			signVal = field >> 7;
			expVal  = (field >> 3) & 'hF;
			// three mantissa bits move to the top of the six kept bits
			mantVal = (field & 'h7) * 8;
		end
		else
		begin
			signVal = 0;
			expVal  = field >> 4;
			mantVal = (field & 'hF) * 4;
		end
		// zero exponent flushes the whole lane, denormals do not exist here
		if (expVal == 0)
		begin
			result = 0;
		end
		else
		begin
			result = signVal * 2048 + (expVal + 8) * 64 + mantVal;
		end
		return result[11:0];
	endfunction

	// a 10-bit linear colour field, shifted up one place with the sign copied on top
	function automatic logic [11:0] refLinear(input logic [9:0] field, input bit isSigned);
		int result;
		result = field * 2;
		if (isSigned && field[9])
		begin
			result = result + 2048;
		end
		return result[11:0];
	endfunction

	// the whole 64-bit pixel, lanes A R G B from the top, each followed by a zero nibble
	function automatic logic [63:0] refExpand(input logic [31:0] src, input logic [1:0] tag);
		bit          isSigned;
		logic [11:0] lanes [4];
		logic [63:0] pix;
		int          i;
		isSigned = (tag[0] == 1'b0);
		if (tag[1])
		begin
			lanes[0] = refFp8Exp12(src[29:22], isSigned);
			lanes[1] = refFp8Exp12({src[21:15], 1'b0}, isSigned);
			lanes[2] = refFp8Exp12(src[14:7], isSigned);
			lanes[3] = refFp8Exp12({src[6:0], 1'b0}, isSigned);
		end
		else
		begin
			lanes[0] = HALF_ONE_12;
			lanes[1] = refLinear(src[29:20], isSigned);
			lanes[2] = refLinear(src[19:10], isSigned);
			lanes[3] = refLinear(src[9:0], isSigned);
		end
		pix = '0;
		for (i = 0; i < 4; i++)
		begin
			pix[63 - 16*i -: 12] = lanes[i];
		end
		return pix;
	endfunction

`endif

// File: sim/tbConvUnit.sv
module tbConvUnit import convPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 50;
	localparam int WORDS_PER_TAG  = 24;
	// minifloat signed and unsigned first, then linear signed and unsigned
	localparam logic [1:0] TAG_ORDER [4] = '{2'd2, 2'd3, 2'd0, 2'd1};

	logic                  clock;
	logic                  arstN;
	logic                  awValid;
	logic                  awReady;
	logic [ADDR_WIDTH-1:0] awAddr;
	logic                  wValid;
	logic                  wReady;
	logic [DATA_WIDTH-1:0] wData;
	logic [STRB_WIDTH-1:0] wStrb;
	logic                  bValid;
	logic                  bReady;
	logic [1:0]            bResp;
	logic                  arValid;
	logic                  arReady;
	logic [ADDR_WIDTH-1:0] arAddr;
	logic                  rValid;
	logic                  rReady;
	logic [DATA_WIDTH-1:0] rData;
	logic [1:0]            rResp;

	// xorshift state
	logic [31:0] rngState;
	// testbench copies of what the registers should hold
	logic [31:0] srcShadow;
	logic [1:0]  fmtShadow;
	// set while a read of a result half is on the bus
	logic        resultRead;
	logic        alphaRead;

	`include "convRefModel.svh"

	convUnit UUT (.*);

	always #10 clock = ~clock;

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		stopRun($sformatf("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected,
			actual));
	endtask

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	// -------------------------------------------------------------------------
	// protocol checks
	// -------------------------------------------------------------------------

	assert property (@(posedge clock) !arstN |-> !bValid && !rValid)
		else stopRun("a response valid was high while reset was held");
	assert property (@(posedge clock) disable iff (!arstN)
		rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
		else stopRun("rValid dropped or the read payload changed before rReady");
	assert property (@(posedge clock) disable iff (!arstN)
		bValid && !bReady |=> bValid && $stable(bResp))
		else stopRun("bValid dropped or bResp changed before bReady");
	assert property (@(posedge clock) disable iff (!arstN) rValid |-> rResp == RESP_OKAY)
		else reportMismatch("rResp", RESP_OKAY, rResp);
	// both halves of the result carry their padding nibbles at the same places
	assert property (@(posedge clock) disable iff (!arstN)
		rValid && resultRead |-> rData[3:0] == 4'h0 && rData[19:16] == 4'h0)
		else reportMismatch("rData padding", 0, {rData[19:16], rData[3:0]});
	assert property (@(posedge clock) disable iff (!arstN)
		rValid && alphaRead |-> rData[31:16] == {HALF_ONE_12, 4'h0})
		else reportMismatch("rData alpha", {HALF_ONE_12, 4'h0}, rData[31:16]);

	// -------------------------------------------------------------------------
	// bus master tasks
	// -------------------------------------------------------------------------

	// ready stays low for a while and the DUT has to keep its response meanwhile
	task automatic idleCycles(input int span);
		repeat (span)
		begin
			@(posedge clock);
			#2;
		end
	endtask

	task automatic writeReg(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] expResp);
		int         cycles;
		int         awDelay;
		int         wDelay;
		bit         awDone;
		bit         wDone;
		bit         awTaken;
		bit         wTaken;
		bit         respSeen;
		logic [1:0] resp;
		awAddr  = addr;
		wData   = data;
		wStrb   = strb;
		// either half may lead by up to two cycles and the slave then holds the first one
		awDelay = nextRandom() % 3;
		wDelay  = nextRandom() % 3;
		awDone  = 1'b0;
		wDone   = 1'b0;
		cycles  = 0;
		// readies are looked at mid-cycle and the handshake lands on the next edge
		while (!awDone || !wDone)
		begin
			if (!awDone && cycles >= awDelay)
			begin
				awValid = 1'b1;
			end
			if (!wDone && cycles >= wDelay)
			begin
				wValid = 1'b1;
			end
			@(negedge clock);
			awTaken = awValid && awReady;
			wTaken  = wValid && wReady;
			@(posedge clock);
			#2;
			// a taken payload moves away so only the slave's held copy can finish the write
			if (awTaken)
			begin
				awValid = 1'b0;
				awAddr  = ~addr;
				awDone  = 1'b1;
			end
			if (wTaken)
			begin
				wValid = 1'b0;
				wData  = ~data;
				wStrb  = ~strb;
				wDone  = 1'b1;
			end
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				if (!awDone)
				begin
					stopRun("write address channel stalled");
				end
				else
				begin
					stopRun("write data channel stalled");
				end
			end
		end
		idleCycles(nextRandom() % 5);
		bReady   = 1'b1;
		respSeen = 1'b0;
		cycles   = 0;
		while (!respSeen)
		begin
			@(negedge clock);
			respSeen = bValid;
			resp     = bResp;
			@(posedge clock);
			#2;
			cycles++;
			if (!respSeen && cycles > TIMEOUT_CYCLES)
			begin
				stopRun("write response channel stalled");
			end
		end
		bReady = 1'b0;
		assert (resp == expResp) else reportMismatch("bResp", expResp, resp);
	endtask

	task automatic readCheck(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] expected,
		input string name);
		int          cycles;
		bit          arTaken;
		bit          dataSeen;
		logic [31:0] data;
		logic [1:0]  resp;
		resultRead = (addr == REG_RES_LO) || (addr == REG_RES_HI);
		alphaRead  = (addr == REG_RES_HI) && !fmtShadow[FMT_MINIFLOAT_BIT];
		arValid    = 1'b1;
		arAddr     = addr;
		cycles     = 0;
		while (arValid)
		begin
			@(negedge clock);
			arTaken = arReady;
			@(posedge clock);
			#2;
			if (arTaken)
			begin
				arValid = 1'b0;
			end
			cycles++;
			if (arValid && cycles > TIMEOUT_CYCLES)
			begin
				stopRun("read address channel stalled");
			end
		end
		idleCycles(nextRandom() % 5);
		rReady   = 1'b1;
		dataSeen = 1'b0;
		cycles   = 0;
		while (!dataSeen)
		begin
			@(negedge clock);
			dataSeen = rValid;
			data     = rData;
			resp     = rResp;
			@(posedge clock);
			#2;
			cycles++;
			if (!dataSeen && cycles > TIMEOUT_CYCLES)
			begin
				stopRun("read data channel stalled");
			end
		end
		rReady     = 1'b0;
		resultRead = 1'b0;
		alphaRead  = 1'b0;
		assert (resp == RESP_OKAY) else reportMismatch("rResp", RESP_OKAY, resp);
		assert (data == expected) else reportMismatch(name, expected, data);
	endtask

	// -------------------------------------------------------------------------
	// register level helpers
	// -------------------------------------------------------------------------

	task automatic writeSource(input logic [31:0] data, input logic [3:0] strb);
		int b;
		writeReg(REG_SRC, data, strb, RESP_OKAY);
		// bytes whose strobe was low keep their old value
		for (b = 0; b < 4; b++)
		begin
			if (strb[b])
			begin
				srcShadow[8*b +: 8] = data[8*b +: 8];
			end
		end
	endtask

	task automatic writeFormat(input logic [31:0] data, input logic [3:0] strb);
		writeReg(REG_FMT, data, strb, RESP_OKAY);
		if (strb[0])
		begin
			fmtShadow = data[1:0];
		end
		readCheck(REG_FMT, {30'b0, fmtShadow}, "rData REG_FMT");
	endtask

	task automatic checkResult();
		logic [63:0] expected;
		expected = refExpand(srcShadow, fmtShadow);
		readCheck(REG_RES_LO, expected[31:0], "rData REG_RES_LO");
		readCheck(REG_RES_HI, expected[63:32], "rData REG_RES_HI");
	endtask

	initial
	begin
		int          t;
		int          i;
		logic [31:0] word;
		clock      = 1'b0;
		arstN      = 1'b0;
		awValid    = 1'b0;
		awAddr     = '0;
		wValid     = 1'b0;
		wData      = '0;
		wStrb      = '0;
		bReady     = 1'b0;
		arValid    = 1'b0;
		arAddr     = '0;
		rReady     = 1'b0;
		rngState   = 32'ha565;
		srcShadow  = '0;
		fmtShadow  = '0;
		resultRead = 1'b0;
		alphaRead  = 1'b0;
		repeat (3) @(posedge clock);
		#2;
		arstN = 1'b1;

		// both writable registers come out of reset cleared
		readCheck(REG_SRC, 32'h0, "rData REG_SRC");
		readCheck(REG_FMT, 32'h0, "rData REG_FMT");

		for (t = 0; t < 4; t++)
		begin
			// upper tag bits are random and must read back as zero
			word      = nextRandom();
			word[1:0] = TAG_ORDER[t];
			writeFormat(word, 4'h1);
			for (i = 0; i < WORDS_PER_TAG; i++)
			begin
				word = nextRandom();
				// clear the A exponent of either layout, or the whole R and B fields
				if (i % 3 == 0)
				begin
					word &= fmtShadow[FMT_UNSIGNED_BIT] ? 32'hC3FF_FFFF : 32'hE1FF_FFFF;
				end
				else if (i % 3 == 1)
				begin
					word &= 32'hFFC0_7F80;
				end
				writeSource(word, 4'hF);
				checkResult();
			end
		end

		// every strobe pattern once on the source register
		for (i = 0; i < 16; i++)
		begin
			writeSource(nextRandom(), i[3:0]);
			readCheck(REG_SRC, srcShadow, "rData REG_SRC");
		end
		// no byte 0 strobe, so the tag stays
		writeFormat(32'hFFFF_FFFC | ~fmtShadow, 4'hE);

		// result offsets refuse writes and keep the expanded value
		writeReg(REG_RES_LO, nextRandom(), 4'hF, RESP_SLVERR);
		writeReg(REG_RES_HI, nextRandom(), 4'hF, RESP_SLVERR);
		checkResult();
		readCheck(REG_SRC, srcShadow, "rData REG_SRC");

		$display(">>> PASS");
		$finish;
	end

endmodule
